// File: bench/uart_props.sv
// Concurrent assertions on the Wishbone handshake and the idle level of the serial output
`timescale 1ns/1ps

module uart_props
	(input clk,
	input reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic busy,
	input logic uart_tx);

	// The slave only answers a request that is still on the bus
	ack_needs_request: assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb)
		else $error("ack seen without cyc and stb");

	// Every ack is a single-cycle pulse
	ack_single_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("ack held for more than one cycle");

	// An idle transmitter leaves the line at the stop level
	tx_idle_high: assert property (@(posedge clk) disable iff (reset) !busy |-> uart_tx)
		else $error("uart_tx low while the transmitter is idle");
endmodule

// Busy is internal to the top level, so the checker sits inside it
bind uart_top uart_props props_i(
	.clk(clk),
	.reset(reset),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.busy(busy),
	.uart_tx(uart_tx));

// File: bench/uart_tb.sv
// Testbench for the UART with a Wishbone master, serial line models and a receive queue model
`timescale 1ns/1ps

module uart_tb;
	import uart_pkg::*;

	// One serial bit lasts one tick period times the ticks per bit
	localparam int BIT_CLOCKS = (TICK_DIVIDE + 1) * TICKS_PER_BIT;
	localparam int TOTAL_FRAMES = 23;
	localparam int WATCHDOG_MARGIN = 4000;
	localparam int WAIT_LIMIT = 12 * BIT_CLOCKS;
	localparam realtime CLOCK_PERIOD = 100.0;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	wb_addr_t adr;
	wb_data_t dat_w;
	wb_data_t dat_r;
	logic ack;
	logic uart_rx;
	logic uart_tx;

	// Expected contents of the receive queue and the sticky overrun flag
	uart_char_t expected_queue[$];
	logic expected_overrun;
	int error_count;
	int test_errors;
	int tests_run;
	int tests_failed;

	uart_top dut_i(
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx));

	initial
	begin
		clk = 1'b0;
		forever
			#(CLOCK_PERIOD / 2) clk = ~clk;
	end

	// Every frame takes ten bit times and the margin covers reset and register polling
	initial
	begin
		#((TOTAL_FRAMES * 10 * BIT_CLOCKS + WATCHDOG_MARGIN) * CLOCK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("Test failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_failure(input string text);
		$display("ERROR: %s", text);
		error_count++;
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("%s: pass", name);
		else
		begin
			tests_failed++;
			$display("%s: FAIL with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// Wishbone classic master that samples ack on the falling edge where it is stable
	task automatic bus_access(input logic write, input wb_addr_t addr, input wb_data_t wdata,
			output wb_data_t rdata, output int waited);
		rdata = '0;
		waited = 0;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = wdata;
		do
		begin
			@(negedge clk);
			waited++;
		end
		while (!ack && waited < WAIT_LIMIT);
		if (ack)
			rdata = dat_r;
		else
			report_failure("the Wishbone slave never acknowledged the access");
		// The strobe stays up through the rising edge that takes the ack
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic read_reg(input wb_addr_t addr, output wb_data_t data);
		int waited;
		bus_access(1'b0, addr, '0, data, waited);
	endtask

	task automatic write_data(input uart_char_t value, output int waited);
		wb_data_t unused;
		bus_access(1'b1, ADDR_DATA, value, unused, waited);
	endtask

	// Drives start bit, eight data bits LSB first and a full stop bit
	task automatic send_serial(input uart_char_t value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		@(negedge clk);
		for (int i = 0; i < 10; i++)
		begin
			uart_rx = frame[i];
			repeat (BIT_CLOCKS) @(negedge clk);
		end
	endtask

	// Finds the start edge on uart_tx and samples each bit in its middle
	task automatic receive_serial(input string name, output uart_char_t value,
			output logic stop_bit);
		int waited;
		value = '0;
		stop_bit = 1'b0;
		waited = 0;
		while (uart_tx !== 1'b0 && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (uart_tx !== 1'b0)
			report_failure({name, ": no start bit appeared on uart_tx"});
		else
		begin
			repeat (BIT_CLOCKS / 2 - 1) @(negedge clk);
			check_value({name, " start bit"}, 16'd0, uart_tx);
			for (int i = 0; i < 8; i++)
			begin
				repeat (BIT_CLOCKS) @(negedge clk);
				value[i] = uart_tx;
			end
			repeat (BIT_CLOCKS) @(negedge clk);
			stop_bit = uart_tx;
		end
	endtask

	// A full queue drops the new character and raises overrun
	function automatic void enqueue_expected(input uart_char_t value);
		if (expected_queue.size() < FIFO_DEPTH)
			expected_queue.push_back(value);
		else
			expected_overrun = 1'b1;
	endfunction

	// An empty queue reads as zero
	function automatic wb_data_t pop_expected();
		if (expected_queue.size() == 0)
			return '0;
		return expected_queue.pop_front();
	endfunction

	function automatic wb_data_t expected_status(input logic tx_busy);
		wb_data_t status;
		status = '0;
		status[STAT_RX_READY] = expected_queue.size() != 0;
		status[STAT_TX_BUSY] = tx_busy;
		status[STAT_OVERRUN] = expected_overrun;
		// Reading STATUS clears the sticky overrun flag
		expected_overrun = 1'b0;
		return status;
	endfunction

	initial
	begin
		uart_char_t sent;
		uart_char_t first;
		uart_char_t second;
		uart_char_t seen;
		wb_data_t got;
		logic stop_bit;
		int waited;
		int polls;

		void'($urandom(7936));
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		uart_rx = 1'b1;
		expected_overrun = 1'b0;
		error_count = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		// Idle state after reset
		read_reg(ADDR_STATUS, got);
		check_value("reset status", expected_status(1'b0), got);
		check_value("reset uart_tx", 16'd1, uart_tx);
		read_reg(ADDR_DATA, got);
		check_value("reset data", pop_expected(), got);
		finish_test("reset");

		// Each written byte is decoded from the line while the write completes
		for (int i = 0; i < 8; i++)
		begin
			sent = uart_char_t'($urandom());
			fork
				begin
					write_data(sent, waited);
					// The frame has just started, so STATUS must report the transmitter busy
					read_reg(ADDR_STATUS, got);
					check_value("transmit busy status", expected_status(1'b1), got);
				end
				receive_serial("transmit", seen, stop_bit);
			join
			check_value("transmit data", sent, seen);
			check_value("transmit stop bit", 16'd1, stop_bit);
		end
		finish_test("transmit");

		// The second write stalls until the first frame has left the line
		first = uart_char_t'($urandom());
		second = uart_char_t'($urandom());
		fork
			begin
				write_data(first, waited);
				write_data(second, waited);
			end
			begin
				receive_serial("backpressure", seen, stop_bit);
				check_value("backpressure first byte", first, seen);
				check_value("backpressure first stop", 16'd1, stop_bit);
				receive_serial("backpressure", seen, stop_bit);
				check_value("backpressure second byte", second, seen);
				check_value("backpressure second stop", 16'd1, stop_bit);
			end
		join
		check_value("backpressure stall", 16'd1, waited >= 9 * BIT_CLOCKS);
		finish_test("backpressure");

		// Characters arrive one at a time and are polled through STATUS and popped through DATA
		for (int i = 0; i < 8; i++)
		begin
			sent = uart_char_t'($urandom());
			send_serial(sent);
			enqueue_expected(sent);
			polls = 0;
			do
			begin
				read_reg(ADDR_STATUS, got);
				polls++;
			end
			while (!got[STAT_RX_READY] && polls < 100);
			if (!got[STAT_RX_READY])
				report_failure("receive: STATUS never reported a ready character");
			read_reg(ADDR_DATA, got);
			check_value("receive data", pop_expected(), got);
		end
		finish_test("receive");

		// Five characters into a four-entry queue drop the last one
		for (int i = 0; i < 5; i++)
		begin
			sent = uart_char_t'($urandom());
			send_serial(sent);
			enqueue_expected(sent);
		end
		read_reg(ADDR_STATUS, got);
		check_value("overrun status", expected_status(1'b0), got);
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			read_reg(ADDR_DATA, got);
			check_value("overrun data", pop_expected(), got);
		end
		read_reg(ADDR_STATUS, got);
		check_value("overrun cleared", expected_status(1'b0), got);
		read_reg(ADDR_DATA, got);
		check_value("overrun empty data", pop_expected(), got);
		finish_test("overrun");

		$display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end
endmodule

// File: list.f
logic/uart_pkg.sv
logic/synchronizer.sv
logic/uart_tick_gen.sv
logic/uart_receive.sv
logic/uart_transmit.sv
logic/uart_rx_fifo.sv
logic/uart_wb_regs.sv
logic/uart_top.sv
bench/uart_props.sv
bench/uart_tb.sv

// File: logic/synchronizer.sv
// Two-flop synchronizer that brings an asynchronous input into the clock domain
`timescale 1ns/1ps

module synchronizer
	#(parameter logic RESET_STATE = 1'b0)
	(input clk,
	input reset,
	input logic data_i,
	output logic data_o);

	// First stage may go metastable, the second one gives it a cycle to settle
	logic stage1;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			stage1 <= RESET_STATE;
			data_o <= RESET_STATE;
		end
		else
		begin
			stage1 <= data_i;
			data_o <= stage1;
		end
	end
endmodule

// File: logic/uart_pkg.sv
// UART package with character and bus types, bit timing, register map and receive record
package uart_pkg;
	// One character on the serial line, and the Wishbone view of it
	typedef logic [7:0] uart_char_t;
	typedef logic [0:0] wb_addr_t;
	typedef logic [7:0] wb_data_t;

	// The sample tick fires once every TICK_DIVIDE + 1 clocks
	localparam int TICK_DIVIDE = 3;
	localparam int TICKS_PER_BIT = 16;
	// From the start edge to the middle of data bit 0 is one and a half bits
	localparam int START_TO_MID = 24;
	localparam int FIFO_DEPTH = 4;

	// Register map
	localparam wb_addr_t ADDR_DATA = 1'b0;
	localparam wb_addr_t ADDR_STATUS = 1'b1;

	// STATUS bit positions, all other bits read as zero
	localparam int STAT_RX_READY = 0;
	localparam int STAT_TX_BUSY = 1;
	localparam int STAT_OVERRUN = 2;

	// Counter widths derived from the constants above
	typedef logic [$clog2(TICK_DIVIDE + 1) - 1:0] tick_div_t;
	typedef logic [$clog2(START_TO_MID + 1) - 1:0] tick_count_t;
	typedef logic [3:0] bit_index_t;
	typedef logic [$clog2(FIFO_DEPTH) - 1:0] fifo_ptr_t;
	typedef logic [$clog2(FIFO_DEPTH + 1) - 1:0] fifo_count_t;

	// A received character, valid for one cycle
	typedef struct packed {
		logic valid;
		uart_char_t data;
	} rx_char_s;
endpackage

// File: logic/uart_receive.sv
// Serial receiver that finds the start bit and samples eight data bits at mid-bit
`timescale 1ns/1ps

module uart_receive
	(input clk,
	input reset,
	input logic tick,
	input logic uart_rx,
	output uart_pkg::rx_char_s rx_char);

	import uart_pkg::*;

	typedef enum logic {
		RX_WAIT_START,
		RX_READ_CHARACTER
	} rx_state_t;

	rx_state_t state_ff;
	rx_state_t state_nxt;
	tick_count_t sample_count_ff;
	tick_count_t sample_count_nxt;
	bit_index_t bit_count_ff;
	bit_index_t bit_count_nxt;
	uart_char_t shift_register;
	logic do_shift;
	logic char_valid;
	logic rx_sync;

	// The line idles high, so the synchronizer comes out of reset at 1
	synchronizer #(.RESET_STATE(1'b1)) rx_synchronizer(
		.clk(clk),
		.reset(reset),
		.data_i(uart_rx),
		.data_o(rx_sync));

	assign rx_char.valid = char_valid;
	assign rx_char.data = shift_register;

	always_comb
	begin
		state_nxt = state_ff;
		sample_count_nxt = sample_count_ff;
		bit_count_nxt = bit_count_ff;
		do_shift = 1'b0;
		char_valid = 1'b0;

		unique case (state_ff)
			RX_WAIT_START:
			begin
				// A low level marks the start bit, count on to the middle of bit 0
				if (!rx_sync)
				begin
					state_nxt = RX_READ_CHARACTER;
					sample_count_nxt = tick_count_t'(START_TO_MID);
					bit_count_nxt = '0;
				end
			end

			RX_READ_CHARACTER:
			begin
				if (tick)
				begin
					if (sample_count_ff == tick_count_t'(1))
					begin
						// This tick is a sample point, the next one is a full bit away
						sample_count_nxt = tick_count_t'(TICKS_PER_BIT);
						if (bit_count_ff == bit_index_t'(8))
						begin
							// Stop bit position, the character is complete
							char_valid = 1'b1;
							state_nxt = RX_WAIT_START;
						end
						else
						begin
							do_shift = 1'b1;
							bit_count_nxt = bit_count_ff + 1'b1;
						end
					end
					else
						sample_count_nxt = sample_count_ff - 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= RX_WAIT_START;
			sample_count_ff <= '0;
			bit_count_ff <= '0;
		end
		else
		begin
			state_ff <= state_nxt;
			sample_count_ff <= sample_count_nxt;
			bit_count_ff <= bit_count_nxt;
		end
	end

	// LSB arrives first, so bits enter at the top and move down
	always_ff @(posedge clk)
	begin
		if (do_shift)
			shift_register <= {rx_sync, shift_register[7:1]};
	end
endmodule

// File: logic/uart_rx_fifo.sv
// Receive queue that holds characters until the host reads them and flags overruns
`timescale 1ns/1ps

module uart_rx_fifo
	(input clk,
	input reset,
	input uart_pkg::rx_char_s rx_char,
	input logic pop,
	output uart_pkg::uart_char_t head,
	output logic not_empty,
	output logic overrun,
	input logic clear_overrun);

	import uart_pkg::*;

	uart_char_t storage[FIFO_DEPTH];
	fifo_ptr_t read_ptr;
	fifo_ptr_t write_ptr;
	fifo_count_t count;
	logic full;
	logic do_pop;
	logic do_write;

	assign full = count == fifo_count_t'(FIFO_DEPTH);
	assign not_empty = count != '0;
	assign head = storage[read_ptr];
	assign do_pop = pop && not_empty;
	// A pop in the same cycle frees a slot, so a full queue still accepts
	assign do_write = rx_char.valid && (!full || do_pop);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
			overrun <= 1'b0;
		end
		else
		begin
			if (do_write)
				write_ptr <= write_ptr == fifo_ptr_t'(FIFO_DEPTH - 1) ? '0 : write_ptr + 1'b1;
			if (do_pop)
				read_ptr <= read_ptr == fifo_ptr_t'(FIFO_DEPTH - 1) ? '0 : read_ptr + 1'b1;
			if (do_write && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_write)
				count <= count - 1'b1;

			// A character dropped in the same cycle as a clear keeps the flag set
			if (rx_char.valid && !do_write)
				overrun <= 1'b1;
			else if (clear_overrun)
				overrun <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_write)
			storage[write_ptr] <= rx_char.data;
	end
endmodule

// File: logic/uart_tick_gen.sv
// Sample tick generator shared by the serial receiver and transmitter
`timescale 1ns/1ps

module uart_tick_gen
	(input clk,
	input reset,
	output logic tick);

	import uart_pkg::*;

	tick_div_t divider;

	// The counter runs down and reloads, so tick is high one clock in TICK_DIVIDE + 1
	assign tick = divider == '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			divider <= tick_div_t'(TICK_DIVIDE);
		else if (divider == '0)
			divider <= tick_div_t'(TICK_DIVIDE);
		else
			divider <= divider - 1'b1;
	end
endmodule

// File: logic/uart_top.sv
// UART peripheral top level with Wishbone registers, receive queue and serial blocks
`timescale 1ns/1ps

module uart_top
	(input clk,
	input reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input uart_pkg::wb_addr_t adr,
	input uart_pkg::wb_data_t dat_w,
	output uart_pkg::wb_data_t dat_r,
	output logic ack,
	input logic uart_rx,
	output logic uart_tx);

	import uart_pkg::*;

	logic tick;
	rx_char_s rx_char;
	uart_char_t head;
	logic not_empty;
	logic overrun;
	logic pop;
	logic clear_overrun;
	logic busy;
	logic tx_start;
	uart_char_t tx_char;

	uart_wb_regs regs_i(
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.head(head),
		.not_empty(not_empty),
		.overrun(overrun),
		.pop(pop),
		.clear_overrun(clear_overrun),
		.busy(busy),
		.tx_start(tx_start),
		.tx_char(tx_char));

	// One tick drives both directions so their bit timing agrees
	uart_tick_gen tick_gen_i(
		.clk(clk),
		.reset(reset),
		.tick(tick));

	uart_receive receive_i(
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.uart_rx(uart_rx),
		.rx_char(rx_char));

	uart_rx_fifo rx_fifo_i(
		.clk(clk),
		.reset(reset),
		.rx_char(rx_char),
		.pop(pop),
		.head(head),
		.not_empty(not_empty),
		.overrun(overrun),
		.clear_overrun(clear_overrun));

	uart_transmit transmit_i(
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.tx_start(tx_start),
		.tx_char(tx_char),
		.busy(busy),
		.uart_tx(uart_tx));
endmodule

// File: logic/uart_transmit.sv
// Serial transmitter that sends start, eight data and stop bits and reports busy
`timescale 1ns/1ps

module uart_transmit
	(input clk,
	input reset,
	input logic tick,
	input logic tx_start,
	input uart_pkg::uart_char_t tx_char,
	output logic busy,
	output logic uart_tx);

	import uart_pkg::*;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t state;
	tick_count_t tick_count;
	bit_index_t bit_count;
	uart_char_t shift_register;
	logic bit_end;

	// Last tick of the current bit period
	assign bit_end = tick && tick_count == tick_count_t'(TICKS_PER_BIT - 1);

	// Line level follows the state, data goes out LSB first
	assign uart_tx = state == TX_START ? 1'b0
		: state == TX_DATA ? shift_register[0]
		: 1'b1;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= TX_IDLE;
			busy <= 1'b0;
			tick_count <= '0;
			bit_count <= '0;
		end
		else
		begin
			unique case (state)
				TX_IDLE:
				begin
					// A request is held until the next tick so the start bit is full length
					if (busy && tick)
					begin
						state <= TX_START;
						tick_count <= '0;
					end
					else if (tx_start)
						busy <= 1'b1;
				end

				TX_START, TX_DATA, TX_STOP:
				begin
					if (bit_end)
						tick_count <= '0;
					else if (tick)
						tick_count <= tick_count + 1'b1;

					if (bit_end)
					begin
						if (state == TX_START)
						begin
							state <= TX_DATA;
							bit_count <= '0;
						end
						else if (state == TX_DATA)
						begin
							bit_count <= bit_count + 1'b1;
							if (bit_count == bit_index_t'(7))
								state <= TX_STOP;
						end
						else
						begin
							// End of the stop bit frees the transmitter
							state <= TX_IDLE;
							busy <= 1'b0;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == TX_IDLE && tx_start)
			shift_register <= tx_char;
		else if (state == TX_DATA && bit_end)
			shift_register <= shift_register >> 1;
	end
endmodule

// File: logic/uart_wb_regs.sv
// Wishbone classic slave with the DATA and STATUS registers of the UART
`timescale 1ns/1ps

module uart_wb_regs
	(input clk,
	input reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input uart_pkg::wb_addr_t adr,
	input uart_pkg::wb_data_t dat_w,
	output uart_pkg::wb_data_t dat_r,
	output logic ack,
	input uart_pkg::uart_char_t head,
	input logic not_empty,
	input logic overrun,
	output logic pop,
	output logic clear_overrun,
	input logic busy,
	output logic tx_start,
	output uart_pkg::uart_char_t tx_char);

	import uart_pkg::*;

	logic request;
	logic read_data;
	logic read_status;
	logic write_data;
	logic ack_nxt;
	wb_data_t status;
	wb_data_t read_value;

	// A request is new until its ack goes out, which keeps a held strobe from repeating
	assign request = cyc && stb && !ack;
	assign read_data = request && !we && adr == ADDR_DATA;
	assign read_status = request && !we && adr == ADDR_STATUS;
	assign write_data = request && we && adr == ADDR_DATA;

	// An empty queue is not popped and the read returns zero
	assign pop = read_data && not_empty;
	// Reading STATUS clears the sticky overrun flag
	assign clear_overrun = read_status && overrun;

	// The write is stalled while a frame is on the line
	assign tx_start = write_data && !busy;
	assign tx_char = dat_w;

	// Writes to STATUS have no effect but still complete
	assign ack_nxt = request && !(write_data && busy);

	always_comb
	begin
		status = '0;
		status[STAT_RX_READY] = not_empty;
		status[STAT_TX_BUSY] = busy;
		status[STAT_OVERRUN] = overrun;
	end

	always_comb
	begin
		read_value = '0;
		if (read_data && not_empty)
			read_value = head;
		else if (read_status)
			read_value = status;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			dat_r <= '0;
		end
		else
		begin
			// ack lasts a single cycle because request is masked while it is high
			ack <= ack_nxt;
			if (ack_nxt)
				dat_r <= read_value;
		end
	end
endmodule
